//--- src/ic_cfg_pkg.sv
// Instruction cache geometry shared by every RTL block.
// Address layout from low to high is byte offset, line index, tag.

package ic_cfg_pkg;

  // Cache shape
  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumLines    = 16;

  // Request address fields
  localparam int unsigned AddrWidth   = 16;
  localparam int unsigned OffsetWidth = 2;
  localparam int unsigned IndexWidth  = $clog2(NumLines);
  localparam int unsigned TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

  // One line holds a single word
  localparam int unsigned DataWidth   = 32;

  typedef logic [IndexWidth-1:0] ic_index_t;
  typedef logic [TagWidth-1:0]   ic_tag_t;
  typedef logic [DataWidth-1:0]  ic_data_t;
  typedef logic [NumWays-1:0]    ic_way_mask_t;

endpackage

//--- src/ic_op_pkg.sv
// Request opcodes for the instruction cache storage.
// Driven with op_i alongside the req_i strobe.

package ic_op_pkg;

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2,
    // Reserved, ignored by the decoder
    OP_NONE   = 2'd3
  } ic_op_e;

endpackage

//--- src/ic_req_decode.sv
// Request decoder for the cache storage.
// Turns a strobed request into bank controls, keeps the round-robin
// victim pointer and stages the lookup tag for the hit compare.

`timescale 1ns/10ps

module ic_req_decode (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  ic_op_pkg::ic_op_e                   op_i,
  input  logic [ic_cfg_pkg::AddrWidth-1:0]    addr_i,
  input  ic_cfg_pkg::ic_data_t                fill_data_i,
  output ic_cfg_pkg::ic_index_t               bank_index_o,
  output ic_cfg_pkg::ic_tag_t                 bank_wtag_o,
  output ic_cfg_pkg::ic_data_t                bank_wdata_o,
  output ic_cfg_pkg::ic_way_mask_t            bank_we_o,
  output logic                                bank_read_o,
  output logic                                bank_inval_o,
  output logic                                lookup_pending_o,
  output ic_cfg_pkg::ic_tag_t                 lookup_tag_o
);

  import ic_cfg_pkg::*;
  import ic_op_pkg::*;

  logic         fill_req;
  ic_tag_t      req_tag;
  // One-hot victim way, rotates on every fill
  ic_way_mask_t victim_q;
  logic         pending_q;
  ic_tag_t      tag_q;

  //////////////////////////////////////////////////
  // Address split and bank controls
  //////////////////////////////////////////////////

  assign req_tag      = addr_i[AddrWidth-1 -: TagWidth];
  assign bank_index_o = addr_i[OffsetWidth +: IndexWidth];
  assign bank_wtag_o  = req_tag;
  assign bank_wdata_o = fill_data_i;

  assign fill_req     = req_i && (op_i == OP_FILL);
  assign bank_we_o    = fill_req ? victim_q : '0;
  assign bank_read_o  = req_i && (op_i == OP_LOOKUP);
  assign bank_inval_o = req_i && (op_i == OP_INVAL);

  //////////////////////////////////////////////////
  // Replacement pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= ic_way_mask_t'(1);
    end else if (fill_req) begin
      victim_q <= {victim_q[NumWays-2:0], victim_q[NumWays-1]};
    end
  end

  // Lookup stage register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= bank_read_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_read_o) begin
      tag_q <= req_tag;
    end
  end

  assign lookup_pending_o = pending_q;
  assign lookup_tag_o     = tag_q;

  // Only one bank may be written per fill
  we_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bank_we_o));

endmodule

//--- src/ic_way_bank.sv
// Storage for one cache way: valid bits, tag array and data array.
// Writes and reads are synchronous, the read result is registered.

`timescale 1ns/10ps

module ic_way_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ic_cfg_pkg::ic_index_t  index_i,
  input  ic_cfg_pkg::ic_tag_t    wtag_i,
  input  ic_cfg_pkg::ic_data_t   wdata_i,
  input  logic                   we_i,
  input  logic                   read_i,
  input  logic                   inval_i,
  output logic                   rd_valid_o,
  output ic_cfg_pkg::ic_tag_t    rd_tag_o,
  output ic_cfg_pkg::ic_data_t   rd_data_o
);

  import ic_cfg_pkg::*;

  logic [NumLines-1:0] valid_q;
  ic_tag_t             tag_mem  [NumLines];
  ic_data_t            data_mem [NumLines];
  logic                rd_valid_q;
  ic_tag_t             rd_tag_q;
  ic_data_t            rd_data_q;

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (inval_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[index_i]  <= wtag_i;
      data_mem[index_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else if (read_i) begin
      rd_valid_q <= valid_q[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_i) begin
      rd_tag_q  <= tag_mem[index_i];
      rd_data_q <= data_mem[index_i];
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_tag_o   = rd_tag_q;
  assign rd_data_o  = rd_data_q;

  // Decoder never issues a fill and a lookup together
  no_wr_rd_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(we_i && read_i));

endmodule

//--- src/ic_hit_select.sv
// Hit stage of the cache storage.
// Compares the staged lookup tag against every way, picks the data of
// the lowest hitting way and flags a multi-way hit as a major alert.

`timescale 1ns/10ps

module ic_hit_select (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lookup_pending_i,
  input  ic_cfg_pkg::ic_tag_t       lookup_tag_i,
  input  ic_cfg_pkg::ic_way_mask_t  way_valid_i,
  input  ic_cfg_pkg::ic_tag_t       way_tag_i  [ic_cfg_pkg::NumWays],
  input  ic_cfg_pkg::ic_data_t      way_data_i [ic_cfg_pkg::NumWays],
  output logic                      rsp_valid_o,
  output logic                      rsp_hit_o,
  output ic_cfg_pkg::ic_data_t      rsp_data_o,
  output logic                      alert_major_o
);

  import ic_cfg_pkg::*;

  ic_way_mask_t hit_mask;
  logic         any_hit;
  logic         multi_hit;
  ic_data_t     hit_data;

  logic         rsp_valid_q;
  logic         rsp_hit_q;
  ic_data_t     rsp_data_q;
  logic         alert_q;

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      hit_mask[w] = lookup_pending_i && way_valid_i[w] && (way_tag_i[w] == lookup_tag_i);
    end
  end

  assign any_hit   = |hit_mask;
  // More than one bit set
  assign multi_hit = |(hit_mask & (hit_mask - ic_way_mask_t'(1)));

  // Lowest hitting way wins and a miss gives zero
  always_comb begin
    hit_data = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_mask[w]) begin
        hit_data = way_data_i[w];
      end
    end
  end

  //////////////////////////////////////////////////
  // Response registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_hit_q   <= 1'b0;
      alert_q     <= 1'b0;
    end else begin
      rsp_valid_q <= lookup_pending_i;
      rsp_hit_q   <= any_hit;
      alert_q     <= multi_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_data_q <= hit_data;
  end

  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_hit_o     = rsp_hit_q;
  assign rsp_data_o    = rsp_data_q;
  assign alert_major_o = alert_q;

endmodule

//--- src/ic_ram_top.sv
// Top of the instruction cache storage.
// Request decoder feeds one bank per way, the hit selector merges
// the bank outputs into a single response two cycles after a lookup.

`timescale 1ns/10ps

module ic_ram_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  ic_op_pkg::ic_op_e                 op_i,
  input  logic [ic_cfg_pkg::AddrWidth-1:0]  addr_i,
  input  ic_cfg_pkg::ic_data_t              fill_data_i,
  output logic                              rsp_valid_o,
  output logic                              rsp_hit_o,
  output ic_cfg_pkg::ic_data_t              rsp_data_o,
  output logic                              alert_major_o
);

  import ic_cfg_pkg::*;

  // Decoder to banks
  ic_index_t    bank_index;
  ic_tag_t      bank_wtag;
  ic_data_t     bank_wdata;
  ic_way_mask_t bank_we;
  logic         bank_read;
  logic         bank_inval;
  // Lookup stage
  logic         lookup_pending;
  ic_tag_t      lookup_tag;
  // Banks to hit selector
  ic_way_mask_t way_valid;
  ic_tag_t      way_tag  [NumWays];
  ic_data_t     way_data [NumWays];

  ic_req_decode u_req_decode (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .op_i             (op_i),
    .addr_i           (addr_i),
    .fill_data_i      (fill_data_i),
    .bank_index_o     (bank_index),
    .bank_wtag_o      (bank_wtag),
    .bank_wdata_o     (bank_wdata),
    .bank_we_o        (bank_we),
    .bank_read_o      (bank_read),
    .bank_inval_o     (bank_inval),
    .lookup_pending_o (lookup_pending),
    .lookup_tag_o     (lookup_tag)
  );

  //////////////////////////////////////////////////
  // Per-way storage
  //////////////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_ways
    ic_way_bank u_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .index_i    (bank_index),
      .wtag_i     (bank_wtag),
      .wdata_i    (bank_wdata),
      .we_i       (bank_we[w]),
      .read_i     (bank_read),
      .inval_i    (bank_inval),
      .rd_valid_o (way_valid[w]),
      .rd_tag_o   (way_tag[w]),
      .rd_data_o  (way_data[w])
    );
  end

  ic_hit_select u_hit_select (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lookup_pending_i (lookup_pending),
    .lookup_tag_i     (lookup_tag),
    .way_valid_i      (way_valid),
    .way_tag_i        (way_tag),
    .way_data_i       (way_data),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_hit_o        (rsp_hit_o),
    .rsp_data_o       (rsp_data_o),
    .alert_major_o    (alert_major_o)
  );

endmodule

//--- bench/tb_ic_ram.sv
// Self-checking random testbench for the instruction cache storage.
// A reference model predicts each response and the check runs two cycles after the lookup.

`timescale 1ns/10ps

module tb_ic_ram;

  import ic_cfg_pkg::*;
  import ic_op_pkg::*;

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned Seed        = 88341;
  localparam int unsigned NumFilled   = 8;
  localparam int unsigned RandOps     = 300;
  localparam int unsigned TestCycles  = 20 + 3 * NumFilled + 10 + 3
                                        + (2 + 3 * NumFilled) + RandOps;
  localparam int unsigned LimitCycles = ResetCycles + TestCycles + 6 * 4 + 200;

  typedef logic [$clog2(NumWays)-1:0] way_idx_t;
  typedef struct packed {
    logic     valid;
    logic     hit;
    logic     alert;
    ic_data_t data;
  } rsp_t;

  logic clk_i, rst_ni, req_i;
  ic_op_e op_i;
  logic [AddrWidth-1:0] addr_i;
  ic_data_t fill_data_i, rsp_data_o;
  logic rsp_valid_o, rsp_hit_o, alert_major_o;

  // Reference model state
  logic     m_valid [NumWays][NumLines];
  ic_tag_t  m_tag   [NumWays][NumLines];
  ic_data_t m_data  [NumWays][NumLines];
  way_idx_t m_ptr;
  rsp_t     stage1, stage2;
  int unsigned lookups_sent, lookups_seen, checks, errors, err_base;
  event checked_ev;

  ic_ram_top dut_i (
    .clk_i, .rst_ni, .req_i, .op_i, .addr_i, .fill_data_i,
    .rsp_valid_o, .rsp_hit_o, .rsp_data_o, .alert_major_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(LimitCycles * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", LimitCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Reference model and response check
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : model_update
    rsp_t        pred;
    ic_index_t   idx;
    ic_tag_t     tag;
    int unsigned hits;
    idx  = addr_i[OffsetWidth +: IndexWidth];
    tag  = addr_i[AddrWidth-1 -: TagWidth];
    pred = '0;
    hits = 0;
    if (!rst_ni) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int l = 0; l < NumLines; l++) m_valid[w][l] = 1'b0;
      end
      m_ptr        = '0;
      lookups_sent = 0;
    end else if (req_i && op_i == OP_LOOKUP) begin
      // Lowest matching way supplies the data
      for (int w = 0; w < NumWays; w++) begin
        if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
          if (hits == 0) pred.data = m_data[w][idx];
          hits++;
        end
      end
      pred.valid = 1'b1;
      pred.hit   = (hits != 0);
      pred.alert = (hits > 1);
      lookups_sent++;
    end else if (req_i && op_i == OP_FILL) begin
      m_valid[m_ptr][idx] = 1'b1;
      m_tag[m_ptr][idx]   = tag;
      m_data[m_ptr][idx]  = fill_data_i;
      m_ptr = (m_ptr == way_idx_t'(NumWays - 1)) ? '0 : m_ptr + 1'b1;
    end else if (req_i && op_i == OP_INVAL) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int l = 0; l < NumLines; l++) m_valid[w][l] = 1'b0;
      end
    end
    stage2 = stage1;
    stage1 = pred;
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, want);
    end
  endtask

  always @(negedge clk_i) begin : rsp_check
    if (rst_ni) begin
      check_equal(32'(rsp_valid_o), 32'(stage2.valid), "rsp_valid_o");
      check_equal(32'(alert_major_o), 32'(stage2.alert), "alert_major_o");
      if (stage2.valid) begin
        check_equal(32'(rsp_hit_o), 32'(stage2.hit), "rsp_hit_o");
        check_equal(rsp_data_o, stage2.data, "rsp_data_o");
        lookups_seen++;
      end
      -> checked_ev;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [AddrWidth-1:0] make_addr(input ic_tag_t tag, input ic_index_t idx);
    logic [OffsetWidth-1:0] off;
    off = OffsetWidth'($urandom());
    return {tag, idx, off};
  endfunction

  task automatic issue(input ic_op_e op, input logic [AddrWidth-1:0] addr, input ic_data_t data);
    @(posedge clk_i);
    req_i       <= 1'b1;
    op_i        <= op;
    addr_i      <= addr;
    fill_data_i <= data;
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    req_i <= 1'b0;
    op_i  <= OP_NONE;
  endtask

  // Idle until every issued lookup has been answered
  task automatic drain();
    go_idle();
    do @(checked_ev); while (lookups_seen != lookups_sent);
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: done, %0d errors", num, name, errors - err_base);
    err_base = errors;
  endtask

  initial begin : main
    logic [AddrWidth-1:0] filled_addr [NumFilled];
    logic [AddrWidth-1:0] alert_addr;
    ic_tag_t     base_tag;
    int unsigned r;
    void'($urandom(Seed));
    {checks, errors, err_base, lookups_seen} = '0;
    req_i       <= 1'b0;
    op_i        <= OP_NONE;
    addr_i      <= '0;
    fill_data_i <= '0;
    rst_ni      <= 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    repeat (20) issue(OP_LOOKUP, make_addr(ic_tag_t'($urandom()), ic_index_t'($urandom())), '0);
    drain();
    report_test(1, "lookups after reset");

    for (int i = 0; i < NumFilled; i++) begin
      filled_addr[i] = make_addr(ic_tag_t'($urandom()), ic_index_t'(i));
      issue(OP_FILL, filled_addr[i], ic_data_t'($urandom()));
    end
    for (int i = 0; i < NumFilled; i++) issue(OP_LOOKUP, filled_addr[i], '0);
    for (int i = 0; i < NumFilled; i++) begin
      issue(OP_LOOKUP, make_addr(ic_tag_t'($urandom()), ic_index_t'(i + NumFilled)), '0);
    end
    drain();
    report_test(2, "fill then lookup");

    // Five tags on one index evict the first
    base_tag = ic_tag_t'($urandom());
    for (int i = 0; i < 5; i++) begin
      issue(OP_FILL, make_addr(base_tag + ic_tag_t'(i), ic_index_t'(12)), ic_data_t'($urandom()));
    end
    for (int i = 0; i < 5; i++) begin
      issue(OP_LOOKUP, make_addr(base_tag + ic_tag_t'(i), ic_index_t'(12)), '0);
    end
    drain();
    report_test(3, "round-robin eviction");

    alert_addr = make_addr(ic_tag_t'($urandom()), ic_index_t'(13));
    issue(OP_FILL, alert_addr, ic_data_t'($urandom()));
    issue(OP_FILL, alert_addr, ic_data_t'($urandom()));
    issue(OP_LOOKUP, alert_addr, '0);
    drain();
    report_test(4, "multi-way hit alert");

    issue(OP_INVAL, '0, '0);
    for (int i = 0; i < NumFilled; i++) issue(OP_LOOKUP, filled_addr[i], '0);
    issue(OP_LOOKUP, alert_addr, '0);
    for (int i = 0; i < NumFilled; i++) begin
      filled_addr[i] = make_addr(ic_tag_t'($urandom()), ic_index_t'(i));
      issue(OP_FILL, filled_addr[i], ic_data_t'($urandom()));
    end
    for (int i = 0; i < NumFilled; i++) issue(OP_LOOKUP, filled_addr[i], '0);
    drain();
    report_test(5, "invalidate then refill");

    // Small tag and index range so that hits and multi-hits occur
    for (int i = 0; i < RandOps; i++) begin
      r = $urandom() % 100;
      alert_addr = make_addr(ic_tag_t'($urandom() % 8), ic_index_t'($urandom() % 4));
      if (r < 50) issue(OP_LOOKUP, alert_addr, '0);
      else if (r < 88) issue(OP_FILL, alert_addr, ic_data_t'($urandom()));
      else if (r < 91) issue(OP_INVAL, alert_addr, '0);
      else if (r < 95) issue(OP_NONE, alert_addr, '0);
      else go_idle();
    end
    drain();
    report_test(6, "random mixed operations");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
src/ic_cfg_pkg.sv
src/ic_op_pkg.sv
src/ic_req_decode.sv
src/ic_way_bank.sv
src/ic_hit_select.sv
src/ic_ram_top.sv
bench/tb_ic_ram.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the cache storage testbench with Verilator, runs it and checks the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ic_ram -f all.f -o sim \
  && ./obj_dir/sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: build or simulation failed"; exit 1; }
